//--- run_sim.sh
#!/bin/sh
# build and run the testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_xtea_ahb -f vlog.f -o sim_xtea

# the simulator exit code is not trusted, the output decides
output=$(./obj_dir/sim_xtea 2>&1 || true)
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -q "Simulation passed"

//--- src/ahb_slave_port.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_slave_port #(
    parameter int ADDR_W = 32
) (
    input  wire                              clk,
    input  wire                              reset_n,

    // ahb-lite slave side
    input  wire  [ADDR_W-1:0]                haddr_i,
    input  wire  [xtea_pkg::DATA_W-1:0]      hwdata_i,
    input  wire                              hsel_i,
    input  wire                              hwrite_i,
    input  wire                              hready_i,
    input  wire  [1:0]                       htrans_i,
    input  wire  [2:0]                       hsize_i,
    output logic [xtea_pkg::DATA_W-1:0]      hrdata_o,
    output logic                             hreadyout_o,
    output logic                             hresp_o,

    // core bus towards the register bank
    core_bus_if.master                       bus
);

    logic                                active;
    logic                                pend_q;
    logic                                write_q;
    logic [xtea_pkg::REG_IDX_W-1:0]      idx_q;
    logic [2:0]                          size_q;
    logic [xtea_pkg::DATA_W-1:0]         wdata_ext;
    logic [xtea_pkg::DATA_W-1:0]         hrdata_q;
    logic                                rd_phase;

    // ----------------------------------------------------------
    // address phase
    // ----------------------------------------------------------
    // only nonseq and seq carry a transfer
    always_comb begin
        case (htrans_i)
            xtea_pkg::HTRANS_NONSEQ,
            xtea_pkg::HTRANS_SEQ:    active = 1'b1;
            xtea_pkg::HTRANS_IDLE,
            xtea_pkg::HTRANS_BUSY:   active = 1'b0;
            default:                 active = 1'b0;
        endcase
    end

    // capture control info when the previous transfer completes
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pend_q  <= 1'b0;
            write_q <= 1'b0;
            idx_q   <= '0;
            size_q  <= '0;
        end else if (hready_i) begin
            pend_q  <= hsel_i & active;
            write_q <= hwrite_i;
            // 64-bit registers, byte offset bits dropped
            idx_q   <= haddr_i[3 +: xtea_pkg::REG_IDX_W];
            size_q  <= hsize_i;
        end
    end

    // ----------------------------------------------------------
    // data phase
    // ----------------------------------------------------------
    // narrow writes land zero-extended in the low lanes
    always_comb begin
        case (size_q)
            3'b000:  wdata_ext = {{(xtea_pkg::DATA_W-8){1'b0}}, hwdata_i[7:0]};
            3'b001:  wdata_ext = {{(xtea_pkg::DATA_W-16){1'b0}}, hwdata_i[15:0]};
            3'b010:  wdata_ext = {{(xtea_pkg::DATA_W-32){1'b0}}, hwdata_i[31:0]};
            default: wdata_ext = hwdata_i;
        endcase
    end

    assign bus.cs    = pend_q;
    assign bus.we    = pend_q & write_q;
    assign bus.addr  = idx_q;
    assign bus.wdata = wdata_ext;

    assign rd_phase = pend_q & ~write_q;

    // last read value kept on the bus between reads
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            hrdata_q <= '0;
        end else if (rd_phase) begin
            hrdata_q <= bus.rdata;
        end
    end

    assign hrdata_o = rd_phase ? bus.rdata : hrdata_q;

    // zero wait states, always okay
    assign hreadyout_o = 1'b1;
    assign hresp_o     = 1'b0;

    // interconnect must not stall a write data phase we never extend
    wr_phase_ready: assert property (@(posedge clk) disable iff (!reset_n)
        (pend_q && write_q) |-> hready_i)
        else $error("ahb write data phase with hready low");

endmodule

`default_nettype wire

//--- src/core_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface core_bus_if;

    // single-cycle access strobe
    logic                              cs;
    logic                              we;
    // register index, not a byte address
    logic [xtea_pkg::REG_IDX_W-1:0]    addr;
    logic [xtea_pkg::DATA_W-1:0]       wdata;
    // combinational from addr
    logic [xtea_pkg::DATA_W-1:0]       rdata;

    // bus adapter side
    modport master (output cs, output we, output addr, output wdata, input rdata);

    // register bank side
    modport slave (input cs, input we, input addr, input wdata, output rdata);

endinterface

`default_nettype wire

//--- src/xtea_ahb_top.sv
`timescale 1ns/1ps
`default_nettype none

module xtea_ahb_top #(
    parameter int NUM_ROUNDS = 32
) (
    input  wire                                  clk,
    input  wire                                  reset_n,

    // ahb-lite slave port
    input  wire  [xtea_pkg::ADDR_W-1:0]          haddr_i,
    input  wire  [xtea_pkg::DATA_W-1:0]          hwdata_i,
    input  wire                                  hsel_i,
    input  wire                                  hwrite_i,
    input  wire                                  hready_i,
    input  wire  [1:0]                           htrans_i,
    input  wire  [2:0]                           hsize_i,
    output logic [xtea_pkg::DATA_W-1:0]          hrdata_o,
    output logic                                 hreadyout_o,
    output logic                                 hresp_o
);

    logic                                start;
    logic                                decrypt;
    logic [2*xtea_pkg::DATA_W-1:0]       key;
    logic [xtea_pkg::DATA_W-1:0]         block;
    logic                                done;
    logic                                busy;
    logic [xtea_pkg::DATA_W-1:0]         result;

    // ----------------------------------------------------------
    // bus adapter -> register bank -> engine
    // ----------------------------------------------------------
    core_bus_if bus_i ();

    ahb_slave_port #(
        .ADDR_W      (xtea_pkg::ADDR_W)
    ) ahb_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .haddr_i     (haddr_i),
        .hwdata_i    (hwdata_i),
        .hsel_i      (hsel_i),
        .hwrite_i    (hwrite_i),
        .hready_i    (hready_i),
        .htrans_i    (htrans_i),
        .hsize_i     (hsize_i),
        .hrdata_o    (hrdata_o),
        .hreadyout_o (hreadyout_o),
        .hresp_o     (hresp_o),
        .bus         (bus_i.master)
    );

    xtea_regs regs_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .bus       (bus_i.slave),
        .start_o   (start),
        .decrypt_o (decrypt),
        .key_o     (key),
        .block_o   (block),
        .done_i    (done),
        .busy_i    (busy),
        .result_i  (result)
    );

    // round count shared with the testbench model
    xtea_core #(
        .NUM_ROUNDS (NUM_ROUNDS)
    ) core_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .start_i   (start),
        .decrypt_i (decrypt),
        .key_i     (key),
        .block_i   (block),
        .busy_o    (busy),
        .done_o    (done),
        .result_o  (result)
    );

endmodule

`default_nettype wire

//--- src/xtea_core.sv
`timescale 1ns/1ps
`default_nettype none

module xtea_core #(
    parameter int NUM_ROUNDS = 32
) (
    input  wire             clk,
    input  wire             reset_n,
    input  wire             start_i,
    input  wire             decrypt_i,
    input  wire  [127:0]    key_i,
    input  wire  [63:0]     block_i,
    output logic            busy_o,
    output logic            done_o,
    output logic [63:0]     result_o
);

    localparam int              CNT_W   = $clog2(NUM_ROUNDS + 1);
    // decrypt walks the sum back down, mod 2^32
    localparam logic [31:0]     SUM_DEC = xtea_pkg::XTEA_DELTA * 32'(NUM_ROUNDS);
    localparam logic [CNT_W-1:0] LAST   = CNT_W'(NUM_ROUNDS - 1);

    logic [31:0]        v0_q;
    logic [31:0]        v1_q;
    logic [31:0]        sum_q;
    logic [127:0]       key_q;
    logic               decrypt_q;
    logic               busy_q;
    logic               done_q;
    logic [CNT_W-1:0]   cnt_q;
    logic [31:0]        v0_n;
    logic [31:0]        v1_n;
    logic [31:0]        sum_n;
    logic               load;

    // feistel mixing of one half
    function automatic logic [31:0] mix(input logic [31:0] v);
        return ((v << 4) ^ (v >> 5)) + v;
    endfunction

    function automatic logic [31:0] key_word(input logic [127:0] k, input logic [1:0] sel);
        return k[{sel, 5'd0} +: 32];
    endfunction

    // ----------------------------------------------------------
    // one full cycle (two feistel rounds) per clock
    // ----------------------------------------------------------
    always_comb begin
        if (decrypt_q) begin
            // v1 first with the old sum, then v0 with the stepped sum
            sum_n = sum_q - xtea_pkg::XTEA_DELTA;
            v1_n  = v1_q - (mix(v0_q) ^ (sum_q + key_word(key_q, sum_q[12:11])));
            v0_n  = v0_q - (mix(v1_n) ^ (sum_n + key_word(key_q, sum_n[1:0])));
        end else begin
            sum_n = sum_q + xtea_pkg::XTEA_DELTA;
            v0_n  = v0_q + (mix(v1_q) ^ (sum_q + key_word(key_q, sum_q[1:0])));
            v1_n  = v1_q + (mix(v0_n) ^ (sum_n + key_word(key_q, sum_n[12:11])));
        end
    end

    // starts while busy are dropped
    assign load = start_i & ~busy_q;

    // ----------------------------------------------------------
    // control
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_q    <= 1'b0;
            done_q    <= 1'b0;
            cnt_q     <= '0;
            decrypt_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (load) begin
                busy_q    <= 1'b1;
                cnt_q     <= '0;
                decrypt_q <= decrypt_i;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
                // last round applied this edge
                if (cnt_q == LAST) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // datapath, key latched so register writes mid-run do not leak in
    always_ff @(posedge clk) begin
        if (load) begin
            v0_q  <= block_i[63:32];
            v1_q  <= block_i[31:0];
            sum_q <= decrypt_i ? SUM_DEC : 32'd0;
            key_q <= key_i;
        end else if (busy_q) begin
            v0_q  <= v0_n;
            v1_q  <= v1_n;
            sum_q <= sum_n;
        end
    end

    assign busy_o   = busy_q;
    assign done_o   = done_q;
    assign result_o = {v0_q, v1_q};

    // done closes a run of exactly NUM_ROUNDS busy cycles
    done_after_busy: assert property (@(posedge clk) disable iff (!reset_n)
        done_o |-> $past(busy_o) && $past(busy_o, NUM_ROUNDS)
                   && !$past(busy_o, NUM_ROUNDS + 1))
        else $error("done without a full run of busy cycles");

endmodule

`default_nettype wire

//--- src/xtea_pkg.sv
`default_nettype none

package xtea_pkg;

    // ----------------------------------------------------------
    // widths
    // ----------------------------------------------------------
    // bus and register word
    localparam int DATA_W    = 64;
    localparam int ADDR_W    = 32;
    // register index lives in haddr[5:3]
    localparam int REG_IDX_W = 3;

    // ----------------------------------------------------------
    // register map, one 64-bit word per index
    // ----------------------------------------------------------
    localparam logic [REG_IDX_W-1:0] REG_CTRL   = 3'd0;
    localparam logic [REG_IDX_W-1:0] REG_STATUS = 3'd1;
    localparam logic [REG_IDX_W-1:0] REG_KEY_LO = 3'd2;
    localparam logic [REG_IDX_W-1:0] REG_KEY_HI = 3'd3;
    localparam logic [REG_IDX_W-1:0] REG_BLOCK  = 3'd4;
    localparam logic [REG_IDX_W-1:0] REG_RESULT = 3'd5;

    // control and status bits
    localparam int CTRL_START_BIT   = 0;
    localparam int CTRL_DECRYPT_BIT = 1;
    localparam int STAT_BUSY_BIT    = 0;
    localparam int STAT_VALID_BIT   = 1;

    // htrans encodings
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_BUSY   = 2'b01;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
    localparam logic [1:0] HTRANS_SEQ    = 2'b11;

    // xtea key schedule constant
    localparam logic [31:0] XTEA_DELTA = 32'h9E3779B9;

endpackage

`default_nettype wire

//--- src/xtea_regs.sv
`timescale 1ns/1ps
`default_nettype none

module xtea_regs (
    input  wire                                clk,
    input  wire                                reset_n,

    core_bus_if.slave                          bus,

    // towards the cipher engine
    output logic                               start_o,
    output logic                               decrypt_o,
    // k0 in bits 31:0 up to k3 in bits 127:96
    output logic [2*xtea_pkg::DATA_W-1:0]      key_o,
    // v0 in the upper half, v1 in the lower half
    output logic [xtea_pkg::DATA_W-1:0]        block_o,
    input  wire                                done_i,
    input  wire                                busy_i,
    input  wire  [xtea_pkg::DATA_W-1:0]        result_i
);

    logic [xtea_pkg::DATA_W-1:0]   key_lo_q;
    logic [xtea_pkg::DATA_W-1:0]   key_hi_q;
    logic [xtea_pkg::DATA_W-1:0]   block_q;
    logic [xtea_pkg::DATA_W-1:0]   result_q;
    logic                          decrypt_q;
    logic                          valid_q;
    logic                          start_q;
    logic                          wr_en;
    logic                          start_req;
    logic [xtea_pkg::DATA_W-1:0]   ctrl_rd;
    logic [xtea_pkg::DATA_W-1:0]   stat_rd;

    // ----------------------------------------------------------
    // write decode
    // ----------------------------------------------------------
    assign wr_en     = bus.cs & bus.we;
    assign start_req = wr_en && (bus.addr == xtea_pkg::REG_CTRL)
                       && bus.wdata[xtea_pkg::CTRL_START_BIT];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            key_lo_q  <= '0;
            key_hi_q  <= '0;
            block_q   <= '0;
            result_q  <= '0;
            decrypt_q <= 1'b0;
            valid_q   <= 1'b0;
            start_q   <= 1'b0;
        end else begin
            // start bit is self-clearing, one pulse per control write
            start_q <= start_req;
            if (wr_en) begin
                case (bus.addr)
                    xtea_pkg::REG_CTRL:   decrypt_q <= bus.wdata[xtea_pkg::CTRL_DECRYPT_BIT];
                    xtea_pkg::REG_KEY_LO: key_lo_q  <= bus.wdata;
                    xtea_pkg::REG_KEY_HI: key_hi_q  <= bus.wdata;
                    xtea_pkg::REG_BLOCK:  block_q   <= bus.wdata;
                    // status and result are read only
                    default: ;
                endcase
            end
            // capture engine output
            if (done_i) begin
                valid_q  <= 1'b1;
                result_q <= result_i;
            end
            // a new request wins over a completion in the same cycle
            if (start_req) begin
                valid_q <= 1'b0;
            end
        end
    end

    assign start_o   = start_q;
    assign decrypt_o = decrypt_q;
    assign key_o     = {key_hi_q, key_lo_q};
    assign block_o   = block_q;

    // ----------------------------------------------------------
    // read mux
    // ----------------------------------------------------------
    always_comb begin
        ctrl_rd = '0;
        ctrl_rd[xtea_pkg::CTRL_DECRYPT_BIT] = decrypt_q;
        stat_rd = '0;
        stat_rd[xtea_pkg::STAT_BUSY_BIT]    = busy_i;
        stat_rd[xtea_pkg::STAT_VALID_BIT]   = valid_q;
        case (bus.addr)
            xtea_pkg::REG_CTRL:   bus.rdata = ctrl_rd;
            xtea_pkg::REG_STATUS: bus.rdata = stat_rd;
            xtea_pkg::REG_KEY_LO: bus.rdata = key_lo_q;
            xtea_pkg::REG_KEY_HI: bus.rdata = key_hi_q;
            xtea_pkg::REG_BLOCK:  bus.rdata = block_q;
            xtea_pkg::REG_RESULT: bus.rdata = result_q;
            // unmapped indices
            default:              bus.rdata = '0;
        endcase
    end

    start_single: assert property (@(posedge clk) disable iff (!reset_n)
        start_o |=> !start_o)
        else $error("start strobe held for two cycles");

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic reset_n_o
);

    // free running clock
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // reset low for the first few edges
    initial begin
        reset_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/tb_xtea_ahb.sv
`timescale 1ns/1ps
`default_nettype none

module tb_xtea_ahb;

    localparam int NUM_ROUNDS  = 32;
    localparam int CLK_NS      = 4;
    localparam int CIPHER_RUNS = 20;
    // encrypt and decrypt per run, plus reset, readback and status tests
    localparam int NUM_TESTS   = 2 * CIPHER_RUNS + 3;
    localparam int WATCHDOG_NS = NUM_TESTS * (NUM_ROUNDS + 20) * CLK_NS * 4;
    localparam logic [2:0] SIZE_DWORD = 3'b011;

    logic                             clk;
    logic                             reset_n;
    logic [xtea_pkg::ADDR_W-1:0]      haddr;
    logic [xtea_pkg::DATA_W-1:0]      hwdata;
    logic                             hsel;
    logic                             hwrite;
    logic                             hready;
    logic [1:0]                       htrans;
    logic [2:0]                       hsize;
    logic [xtea_pkg::DATA_W-1:0]      hrdata;
    logic                             hreadyout;
    logic                             hresp;

    // results waiting for the checker
    string                            name_q[$];
    logic [63:0]                      got_q[$];
    logic [63:0]                      exp_q[$];
    event                             result_ev;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_NS),
        .RESET_CYCLES (4)
    ) clk_gen_i (
        .clk_o     (clk),
        .reset_n_o (reset_n)
    );

    xtea_ahb_top #(
        .NUM_ROUNDS (NUM_ROUNDS)
    ) dut_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .haddr_i     (haddr),
        .hwdata_i    (hwdata),
        .hsel_i      (hsel),
        .hwrite_i    (hwrite),
        .hready_i    (hready),
        .htrans_i    (htrans),
        .hsize_i     (hsize),
        .hrdata_o    (hrdata),
        .hreadyout_o (hreadyout),
        .hresp_o     (hresp)
    );

    // ----------------------------------------------------------
    // reference model and helpers
    // ----------------------------------------------------------
    // xtea on {v0, v1}, k0 in key bits 31:0
    function automatic logic [63:0] xtea_ref(input logic [127:0] key, input logic [63:0] blk,
                                             input logic decrypt, input int rounds);
        logic [31:0] v0;
        logic [31:0] v1;
        logic [31:0] sum;
        logic [31:0] k [4];
        v0 = blk[63:32];
        v1 = blk[31:0];
        for (int i = 0; i < 4; i++) begin
            k[i] = key[32*i +: 32];
        end
        sum = decrypt ? 32'(rounds) * xtea_pkg::XTEA_DELTA : 32'd0;
        for (int r = 0; r < rounds; r++) begin
            if (decrypt) begin
                v1  = v1 - ((((v0 << 4) ^ (v0 >> 5)) + v0) ^ (sum + k[sum[12:11]]));
                sum = sum - xtea_pkg::XTEA_DELTA;
                v0  = v0 - ((((v1 << 4) ^ (v1 >> 5)) + v1) ^ (sum + k[sum[1:0]]));
            end else begin
                v0  = v0 + ((((v1 << 4) ^ (v1 >> 5)) + v1) ^ (sum + k[sum[1:0]]));
                sum = sum + xtea_pkg::XTEA_DELTA;
                v1  = v1 + ((((v0 << 4) ^ (v0 >> 5)) + v0) ^ (sum + k[sum[12:11]]));
            end
        end
        return {v0, v1};
    endfunction

    function automatic logic [63:0] random_word();
        return {$urandom(), $urandom()};
    endfunction

    // narrow writes keep only the low lanes
    function automatic logic [63:0] zero_extend(input logic [63:0] data, input logic [2:0] size);
        if (size >= SIZE_DWORD) begin
            return data;
        end
        return data & ((64'd1 << (8 << size)) - 64'd1);
    endfunction

    function automatic logic [63:0] ctrl_word(input logic decrypt);
        logic [63:0] w;
        w = '0;
        w[xtea_pkg::CTRL_START_BIT]   = 1'b1;
        w[xtea_pkg::CTRL_DECRYPT_BIT] = decrypt;
        return w;
    endfunction

    function automatic logic [63:0] status_word(input logic busy, input logic valid);
        logic [63:0] w;
        w = '0;
        w[xtea_pkg::STAT_BUSY_BIT]  = busy;
        w[xtea_pkg::STAT_VALID_BIT] = valid;
        return w;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // hand a result to the checker process
    task automatic expect_result(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        name_q.push_back(name);
        got_q.push_back(got);
        exp_q.push_back(exp);
        -> result_ev;
    endtask

    // ----------------------------------------------------------
    // ahb driver
    // ----------------------------------------------------------
    task automatic ahb_write(input logic [2:0] idx, input logic [63:0] data,
                             input logic [2:0] size);
        @(posedge clk);
        haddr  <= 32'(idx) << 3;
        hsel   <= 1'b1;
        hwrite <= 1'b1;
        htrans <= xtea_pkg::HTRANS_NONSEQ;
        hsize  <= size;
        // address sampled here, data phase follows
        @(posedge clk);
        hwdata <= data;
        hsel   <= 1'b0;
        hwrite <= 1'b0;
        htrans <= xtea_pkg::HTRANS_IDLE;
        hsize  <= SIZE_DWORD;
    endtask

    task automatic ahb_read(input logic [2:0] idx, output logic [63:0] data);
        @(posedge clk);
        haddr  <= 32'(idx) << 3;
        hsel   <= 1'b1;
        hwrite <= 1'b0;
        htrans <= xtea_pkg::HTRANS_NONSEQ;
        hsize  <= SIZE_DWORD;
        @(posedge clk);
        hsel   <= 1'b0;
        htrans <= xtea_pkg::HTRANS_IDLE;
        // middle of the data phase
        @(negedge clk);
        data = hrdata;
    endtask

    // poll until the result is valid, watchdog bounds the loop
    task automatic wait_valid(output logic [63:0] stat);
        do begin
            ahb_read(xtea_pkg::REG_STATUS, stat);
        end while (!stat[xtea_pkg::STAT_VALID_BIT]);
    endtask

    task automatic load_job(input logic [127:0] key, input logic [63:0] blk, input logic dec);
        ahb_write(xtea_pkg::REG_KEY_LO, key[63:0], SIZE_DWORD);
        ahb_write(xtea_pkg::REG_KEY_HI, key[127:64], SIZE_DWORD);
        ahb_write(xtea_pkg::REG_BLOCK, blk, SIZE_DWORD);
        ahb_write(xtea_pkg::REG_CTRL, ctrl_word(dec), SIZE_DWORD);
    endtask

    task automatic run_cipher(input logic [127:0] key, input logic [63:0] blk, input logic dec,
                              output logic [63:0] res);
        logic [63:0] stat;
        load_job(key, blk, dec);
        wait_valid(stat);
        ahb_read(xtea_pkg::REG_RESULT, res);
    endtask

    // ----------------------------------------------------------
    // checkers and watchdog
    // ----------------------------------------------------------
    initial begin : result_checker
        forever begin
            @(result_ev);
            while (got_q.size() != 0) begin
                check_value(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
            end
        end
    end

    // zero wait states and okay on every cycle
    always @(negedge clk) begin
        check_value("hreadyout_o", 64'(hreadyout), 64'd1);
        check_value("hresp_o", 64'(hresp), 64'd0);
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    // ----------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------
    initial begin : stimulus
        logic [63:0]  wdata;
        logic [63:0]  rdata;
        logic [127:0] key;
        logic [63:0]  plain;
        logic [63:0]  cipher;
        haddr  = '0;
        hwdata = '0;
        hsel   = 1'b0;
        hwrite = 1'b0;
        hready = 1'b1;
        htrans = xtea_pkg::HTRANS_IDLE;
        hsize  = SIZE_DWORD;
        void'($urandom(32'h33967c19));
        wait (reset_n);

        // every index reads zero after reset, unmapped ones too
        for (int i = 0; i < 8; i++) begin
            ahb_read(3'(i), rdata);
            check_value("hrdata_o after reset", rdata, 64'd0);
        end

        // full width readback
        key = {random_word(), random_word()};
        plain = random_word();
        ahb_write(xtea_pkg::REG_KEY_LO, key[63:0], SIZE_DWORD);
        ahb_write(xtea_pkg::REG_KEY_HI, key[127:64], SIZE_DWORD);
        ahb_write(xtea_pkg::REG_BLOCK, plain, SIZE_DWORD);
        ahb_read(xtea_pkg::REG_KEY_LO, rdata);
        check_value("hrdata_o key_lo", rdata, key[63:0]);
        ahb_read(xtea_pkg::REG_KEY_HI, rdata);
        check_value("hrdata_o key_hi", rdata, key[127:64]);
        ahb_read(xtea_pkg::REG_BLOCK, rdata);
        check_value("hrdata_o block", rdata, plain);

        // byte, halfword and word writes
        for (int s = 0; s < 3; s++) begin
            wdata = random_word();
            ahb_write(xtea_pkg::REG_BLOCK, wdata, 3'(s));
            ahb_read(xtea_pkg::REG_BLOCK, rdata);
            check_value("hrdata_o block narrow", rdata, zero_extend(wdata, 3'(s)));
            ahb_write(xtea_pkg::REG_KEY_HI, wdata, 3'(s));
            ahb_read(xtea_pkg::REG_KEY_HI, rdata);
            check_value("hrdata_o key_hi narrow", rdata, zero_extend(wdata, 3'(s)));
        end

        // encrypt, then decrypt the result back
        for (int n = 0; n < CIPHER_RUNS; n++) begin
            key = {random_word(), random_word()};
            plain = random_word();
            run_cipher(key, plain, 1'b0, cipher);
            expect_result("hrdata_o encrypt", cipher, xtea_ref(key, plain, 1'b0, NUM_ROUNDS));
            run_cipher(key, cipher, 1'b1, rdata);
            expect_result("hrdata_o decrypt", rdata, plain);
            expect_result("hrdata_o decrypt model", rdata,
                          xtea_ref(key, cipher, 1'b1, NUM_ROUNDS));
        end

        // busy right after start, a second start is dropped
        key = {random_word(), random_word()};
        plain = random_word();
        load_job(key, plain, 1'b0);
        ahb_read(xtea_pkg::REG_STATUS, rdata);
        check_value("hrdata_o status running", rdata, status_word(1'b1, 1'b0));
        ahb_write(xtea_pkg::REG_BLOCK, ~plain, SIZE_DWORD);
        ahb_write(xtea_pkg::REG_CTRL, ctrl_word(1'b0), SIZE_DWORD);
        wait_valid(rdata);
        check_value("hrdata_o status done", rdata, status_word(1'b0, 1'b1));
        ahb_read(xtea_pkg::REG_RESULT, rdata);
        expect_result("hrdata_o result after second start", rdata,
                      xtea_ref(key, plain, 1'b0, NUM_ROUNDS));

        // let the checker drain
        -> result_ev;
        @(posedge clk);
        if (got_q.size() == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("results were left unchecked at the end of the run");
            $display("Simulation failed");
            $fatal(1, "unchecked results");
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
src/xtea_pkg.sv
src/core_bus_if.sv
src/ahb_slave_port.sv
src/xtea_regs.sv
src/xtea_core.sv
src/xtea_ahb_top.sv
verification/tb_clock_gen.sv
verification/tb_xtea_ahb.sv
